// File: Makefile
VERILATOR ?= verilator
TOP       ?= dircc_processing_tb
FILELIST  ?= dircc_processing.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dircc_processing.f
+incdir+verilog
verilog/dircc_types_pkg.sv
verilog/dircc_packet_receiver.sv
verilog/dircc_packet_sender.sv
verilog/dircc_status_register.sv
verilog/dircc_receive_handler.sv
verilog/dircc_send_handler.sv
verilog/dircc_processing.sv
tb/dircc_processing_tb.sv

// File: tb/dircc_processing_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_processing_tb;

    import dircc_types_pkg::*;

    localparam int num_rounds    = 48;
    localparam int max_packets   = num_rounds * (1 + `DIRCC_NUM_PORTS);
    localparam int clk_period    = 4;
    localparam int timeout_ns    = max_packets * 200 * clk_period;
    localparam int settle_cycles = 30;
    localparam int pkt_width     = $bits(packet_t);

    // input framing variants
    localparam int frame_good      = 0;
    localparam int frame_early_eop = 1;
    localparam int frame_sop_mid   = 2;

    logic clk = 1'b0;
    logic reset_n;
    hw_addr_t address;
    beat_t input_data;
    logic input_startofpacket;
    logic input_endofpacket;
    logic input_valid;
    logic input_ready;
    beat_t output_data;
    logic output_startofpacket;
    logic output_endofpacket;
    logic output_valid;
    logic output_ready;
    logic [`DIRCC_MEM_ADDR_WIDTH-1:0] mem_address;
    logic mem_write;
    logic [`DIRCC_MEM_WIDTH-1:0] mem_writedata;
    logic [`DIRCC_MEM_WIDTH-1:0] mem_readdata;

    integer seed;
    int error_count = 0;
    int check_count = 0;
    int beat_idx = 0;
    packet_t rx_packet;
    packet_t exp_q[$];
    packet_t got_q[$];

    // reference state
    accum_t     m_accum;
    port_mask_t m_pending;
    lamport_t   m_lamport;

    always #(clk_period / 2) clk = ~clk;

    dircc_processing dircc_processing_i (
        .clk                  (clk),
        .reset_n              (reset_n),
        .address              (address),
        .input_data           (input_data),
        .input_startofpacket  (input_startofpacket),
        .input_endofpacket    (input_endofpacket),
        .input_valid          (input_valid),
        .input_ready          (input_ready),
        .output_data          (output_data),
        .output_startofpacket (output_startofpacket),
        .output_endofpacket   (output_endofpacket),
        .output_valid         (output_valid),
        .output_ready         (output_ready),
        .mem_address          (mem_address),
        .mem_write            (mem_write),
        .mem_writedata        (mem_writedata),
        .mem_readdata         (mem_readdata)
    );

    task automatic check_value(input string name, input logic [pkt_width-1:0] expected,
                               input logic [pkt_width-1:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // every stimulus cycle goes through here, sink stalls about a quarter of the time
    task automatic next_cycle();
        @(negedge clk);
        output_ready = (($random(seed) & 3) != 0);
    endtask

    task automatic send_beat(input beat_t data, input logic sop, input logic eop);
        int gap;
        gap = $random(seed) & 3;
        repeat (gap) begin
            next_cycle();
            input_valid = 1'b0;
        end
        next_cycle();
        input_valid         = 1'b1;
        input_data          = data;
        input_startofpacket = sop;
        input_endofpacket   = eop;
        while (!input_ready)    // ready only moves on posedge
            next_cycle();
    endtask

    task automatic send_packet(input packet_t pkt, input int framing);
        beat_t beats[`DIRCC_BEATS];
        for (int i = 0; i < `DIRCC_BEATS; i++)
            beats[i] = pkt[(`DIRCC_BEATS - 1 - i) * `DIRCC_DATA_WIDTH +: `DIRCC_DATA_WIDTH];
        case (framing)
            frame_early_eop: begin
                send_beat(beats[0], 1'b1, 1'b0);
                send_beat(beats[1], 1'b0, 1'b1);
            end
            frame_sop_mid: begin
                send_beat(beats[0], 1'b1, 1'b0);
                send_beat(beats[1], 1'b1, 1'b0);
                send_beat(beats[2], 1'b0, 1'b1);
            end
            default: begin
                send_beat(beats[0], 1'b1, 1'b0);
                send_beat(beats[1], 1'b0, 1'b0);
                send_beat(beats[2], 1'b0, 1'b1);
            end
        endcase
        next_cycle();
        input_valid         = 1'b0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
        // a whole packet is held until handled, a dropped one frees the input
        check_value("input ready after last beat", framing != frame_good, input_ready);
    endtask

    task automatic host_write(input logic [`DIRCC_MEM_ADDR_WIDTH-1:0] addr,
                              input logic [`DIRCC_MEM_WIDTH-1:0] data);
        next_cycle();
        mem_address   = addr;
        mem_write     = 1'b1;
        mem_writedata = data;
        next_cycle();
        mem_write = 1'b0;
    endtask

    task automatic host_read(input logic [`DIRCC_MEM_ADDR_WIDTH-1:0] addr,
                             output logic [`DIRCC_MEM_WIDTH-1:0] data);
        next_cycle();
        mem_address = addr;
        next_cycle();   // read data is registered
        data = mem_readdata;
    endtask

    task automatic model_receive(input packet_t pkt);
        port_t mark;
        mark = port_t'(pkt.data[`DIRCC_MEM_WIDTH +: $bits(port_t)]);
        m_accum = m_accum + pkt.data[`DIRCC_MEM_WIDTH-1:0];
        m_pending[mark] = 1'b1;
        if (pkt.lamport > m_lamport)
            m_lamport = pkt.lamport;
        m_lamport = m_lamport + 32'd1;
    endtask

    // one send per pending bit, highest port first
    task automatic model_drain();
        packet_t pkt;
        for (int p = `DIRCC_NUM_PORTS - 1; p >= 0; p--) begin
            if (m_pending[p]) begin
                m_lamport = m_lamport + 32'd1;
                pkt.dest_addr.hw_addr = address + hw_addr_t'(p + 1);
                pkt.dest_addr.sw_addr = 2'b00;
                pkt.dest_addr.port    = '0;
                pkt.src_addr.hw_addr  = address;
                pkt.src_addr.sw_addr  = 2'b00;
                pkt.src_addr.port     = port_t'(p);
                pkt.lamport           = m_lamport;
                pkt.data              = beat_t'(m_accum);
                m_pending[p] = 1'b0;
                exp_q.push_back(pkt);
            end
        end
    endtask

    task automatic finish_round(input string name);
        logic [`DIRCC_MEM_WIDTH-1:0] value;
        packet_t exp_pkt;
        packet_t got_pkt;
        while (got_q.size() < exp_q.size())
            next_cycle();
        repeat (settle_cycles) next_cycle();    // catch extra packets
        check_value({name, " packet count"}, exp_q.size(), got_q.size());
        while (exp_q.size() > 0 && got_q.size() > 0) begin
            exp_pkt = exp_q.pop_front();
            got_pkt = got_q.pop_front();
            check_value({name, " dest"}, exp_pkt.dest_addr, got_pkt.dest_addr);
            check_value({name, " src"}, exp_pkt.src_addr, got_pkt.src_addr);
            check_value({name, " lamport"}, exp_pkt.lamport, got_pkt.lamport);
            check_value({name, " payload"}, exp_pkt.data, got_pkt.data);
        end
        exp_q.delete();
        got_q.delete();
        host_read(0, value);
        check_value({name, " reg accum"}, m_accum, value);
        host_read(1, value);
        check_value({name, " reg pending"}, m_pending, value);
        host_read(2, value);
        check_value({name, " reg lamport"}, m_lamport[`DIRCC_MEM_WIDTH-1:0], value);
    endtask

    // output stream collector
    always @(posedge clk) begin
        if (reset_n && output_valid && output_ready) begin
            check_value("output sop", beat_idx == 0, output_startofpacket);
            check_value("output eop", beat_idx == `DIRCC_BEATS - 1, output_endofpacket);
            rx_packet[(`DIRCC_BEATS - 1 - beat_idx) * `DIRCC_DATA_WIDTH +: `DIRCC_DATA_WIDTH]
                = output_data;
            if (beat_idx == `DIRCC_BEATS - 1) begin
                got_q.push_back(rx_packet);
                beat_idx = 0;
            end else begin
                beat_idx++;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, output packets missing or stream hung",
                 timeout_ns);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        packet_t pkt;
        port_mask_t mask;
        accum_t acc_value;
        int kind;
        seed                = 32'h52bc;
        reset_n             = 1'b0;
        input_data          = '0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
        input_valid         = 1'b0;
        output_ready        = 1'b0;
        mem_address         = '0;
        mem_write           = 1'b0;
        mem_writedata       = '0;
        address             = hw_addr_t'($random(seed));
        m_accum             = '0;
        m_pending           = '0;
        m_lamport           = '0;
        repeat (16) @(negedge clk);
        reset_n = 1'b1;

        for (int r = 0; r < num_rounds; r++) begin
            kind = r % 8;
            pkt = {$random(seed), $random(seed), $random(seed)};
            if (($random(seed) & 1) == 0)
                pkt.lamport = pkt.lamport & 32'hff;   // let the node's own time win sometimes
            case (kind)
                4: begin
                    acc_value = accum_t'($random(seed));
                    host_write(0, acc_value);
                    m_accum = acc_value;
                    send_packet(pkt, frame_good);
                    model_receive(pkt);
                    model_drain();
                    finish_round("accum write");
                end
                5: begin
                    send_packet(pkt, frame_early_eop);
                    finish_round("early eop");
                end
                6: begin
                    send_packet(pkt, frame_sop_mid);
                    finish_round("sop mid packet");
                end
                7: begin
                    mask = port_mask_t'($random(seed));
                    if (mask == '0)
                        mask = 4'b1011;
                    host_write(1, `DIRCC_MEM_WIDTH'(mask));
                    m_pending = mask;
                    model_drain();
                    finish_round("pending write");
                end
                default: begin
                    send_packet(pkt, frame_good);
                    model_receive(pkt);
                    model_drain();
                    finish_round("packet");
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/dircc_config.svh
`ifndef DIRCC_CONFIG_SVH
`define DIRCC_CONFIG_SVH

// stream side
`define DIRCC_DATA_WIDTH 32
`define DIRCC_BEATS 3

// device
`define DIRCC_NUM_PORTS 4
`define DIRCC_HW_ADDR_WIDTH 12

// host port
`define DIRCC_MEM_ADDR_WIDTH 2
`define DIRCC_MEM_WIDTH 16

`endif

// File: verilog/dircc_packet_receiver.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_packet_receiver (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire dircc_types_pkg::beat_t     data,
    input  wire                             startofpacket,
    input  wire                             endofpacket,
    input  wire                             valid,
    input  wire                             packet_handled,
    output logic                            ready,
    output dircc_types_pkg::packet_t        packet_data,
    output logic                            receive_done
);

    localparam int count_width = $clog2(`DIRCC_BEATS);
    localparam logic [count_width-1:0] last_beat = count_width'(`DIRCC_BEATS - 1);

    logic [count_width-1:0] beat_count;
    logic in_packet;
    logic hold;
    logic hold_next;
    logic fire;
    logic beat_ok;
    logic last_ok;

    assign fire = valid && ready;

    // sop only on the first beat, eop only on the last
    assign beat_ok = (startofpacket == !in_packet) && (endofpacket == (beat_count == last_beat));
    assign last_ok = fire && beat_ok && (beat_count == last_beat);

    always_comb begin
        hold_next = hold;
        if (packet_handled)
            hold_next = 1'b0;
        else if (last_ok)
            hold_next = 1'b1;   // keep packet until the handler is done
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_packet    <= 1'b0;
            beat_count   <= '0;
            hold         <= 1'b0;
            ready        <= 1'b0;
            receive_done <= 1'b0;
        end else begin
            hold         <= hold_next;
            ready        <= !hold_next;
            receive_done <= last_ok;
            if (fire) begin
                if (beat_ok && beat_count != last_beat) begin
                    in_packet  <= 1'b1;
                    beat_count <= beat_count + 1'b1;
                end else begin
                    // last beat, stray beat or broken framing
                    in_packet  <= 1'b0;
                    beat_count <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire)
            packet_data <= {packet_data[$bits(packet_data)-`DIRCC_DATA_WIDTH-1:0], data};
    end

endmodule

`default_nettype wire

// File: verilog/dircc_packet_sender.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_packet_sender (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             write_packet,
    input  wire dircc_types_pkg::packet_t   packet_data,
    input  wire                             ready,
    output dircc_types_pkg::beat_t          data,
    output logic                            startofpacket,
    output logic                            endofpacket,
    output logic                            valid,
    output logic                            sending
);

    localparam int count_width = $clog2(`DIRCC_BEATS);
    localparam logic [count_width-1:0] last_beat = count_width'(`DIRCC_BEATS - 1);

    logic [count_width-1:0] beat_count;
    logic [`DIRCC_BEATS*`DIRCC_DATA_WIDTH-1:0] shift;
    logic active;
    logic accepted;

    assign accepted = active && ready;

    assign valid         = active;
    assign sending       = active;
    assign data          = shift[$bits(shift)-1 -: `DIRCC_DATA_WIDTH];  // current beat on top
    assign startofpacket = active && (beat_count == '0);
    assign endofpacket   = active && (beat_count == last_beat);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            active     <= 1'b0;
            beat_count <= '0;
        end else if (write_packet) begin
            active     <= 1'b1;
            beat_count <= '0;
        end else if (accepted) begin
            if (beat_count == last_beat) begin
                active     <= 1'b0;
                beat_count <= '0;
            end else begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_packet)
            shift <= packet_data;
        else if (accepted)
            shift <= shift << `DIRCC_DATA_WIDTH;
    end

endmodule

`default_nettype wire

// File: verilog/dircc_processing.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_processing (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire dircc_types_pkg::hw_addr_t  address,

    input  wire dircc_types_pkg::beat_t     input_data,
    input  wire                             input_startofpacket,
    input  wire                             input_endofpacket,
    input  wire                             input_valid,
    output logic                            input_ready,

    output dircc_types_pkg::beat_t          output_data,
    output logic                            output_startofpacket,
    output logic                            output_endofpacket,
    output logic                            output_valid,
    input  wire                             output_ready,

    input  wire [`DIRCC_MEM_ADDR_WIDTH-1:0] mem_address,
    input  wire                             mem_write,
    input  wire [`DIRCC_MEM_WIDTH-1:0]      mem_writedata,
    output logic [`DIRCC_MEM_WIDTH-1:0]     mem_readdata
);

    import dircc_types_pkg::*;

    packet_t       packet_in;
    packet_t       packet_out;
    logic          receive_done;
    logic          packet_handled;
    logic          write_packet;
    logic          sending;
    lamport_t      lamport;

    device_state_t read_state;
    device_state_t write_state;
    logic          write_state_valid;
    device_state_t rx_state;
    logic          rx_state_valid;
    device_state_t send_state;
    device_state_t send_next_state;
    beat_t         send_payload;
    port_t         send_port;
    logic          send_go;

    dircc_packet_receiver packet_receiver (
        .clk            (clk),
        .reset_n        (reset_n),
        .data           (input_data),
        .startofpacket  (input_startofpacket),
        .endofpacket    (input_endofpacket),
        .valid          (input_valid),
        .packet_handled (packet_handled),
        .ready          (input_ready),
        .packet_data    (packet_in),
        .receive_done   (receive_done)
    );

    dircc_packet_sender packet_sender (
        .clk            (clk),
        .reset_n        (reset_n),
        .write_packet   (write_packet),
        .packet_data    (packet_out),
        .ready          (output_ready),
        .data           (output_data),
        .startofpacket  (output_startofpacket),
        .endofpacket    (output_endofpacket),
        .valid          (output_valid),
        .sending        (sending)
    );

    dircc_status_register status_register (
        .clk                (clk),
        .reset_n            (reset_n),
        .mem_address        (mem_address),
        .mem_write          (mem_write),
        .mem_writedata      (mem_writedata),
        .write_state        (write_state),
        .write_state_valid  (write_state_valid),
        .lamport_low        (lamport[`DIRCC_MEM_WIDTH-1:0]),
        .mem_readdata       (mem_readdata),
        .read_state         (read_state)
    );

    dircc_receive_handler receive_handler (
        .clk                (clk),
        .reset_n            (reset_n),
        .packet_in          (packet_in),
        .receive_done       (receive_done),
        .read_state         (read_state),
        .write_state        (rx_state),
        .write_state_valid  (rx_state_valid),
        .packet_handled     (packet_handled)
    );

    dircc_send_handler send_handler (
        .read_state (read_state),
        .port_index (send_port),
        .payload    (send_payload),
        .next_state (send_next_state)
    );

    // highest pending port wins
    always_comb begin
        send_port = '0;
        for (int i = 0; i < `DIRCC_NUM_PORTS; i++) begin
            if (read_state.pending[i])
                send_port = port_t'(i);
        end
    end

    // receive first, one send in flight at a time
    assign send_go = !receive_done && (|read_state.pending) && !sending && !write_packet;

    // send write is registered alongside write_packet, never overlaps a receive write
    assign write_state       = rx_state_valid ? rx_state : send_state;
    assign write_state_valid = rx_state_valid || write_packet;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lamport      <= '0;
            write_packet <= 1'b0;
        end else begin
            write_packet <= send_go;
            if (receive_done)
                lamport <= ((lamport > packet_in.lamport) ? lamport : packet_in.lamport) + 1'b1;
            else if (send_go)
                lamport <= lamport + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (send_go) begin
            packet_out.dest_addr <= '{
                hw_addr: hw_addr_t'(address + hw_addr_t'(send_port) + 1'b1),
                sw_addr: '0,
                port:    '0
            };
            packet_out.src_addr <= '{
                hw_addr: address,
                sw_addr: '0,
                port:    send_port
            };
            packet_out.lamport <= lamport + 1'b1;  // stamped with the new time
            packet_out.data    <= send_payload;
            send_state         <= send_next_state;
        end
    end

endmodule

`default_nettype wire

// File: verilog/dircc_receive_handler.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_receive_handler (
    input  wire                                     clk,
    input  wire                                     reset_n,
    input  wire dircc_types_pkg::packet_t           packet_in,
    input  wire                                     receive_done,
    input  wire dircc_types_pkg::device_state_t     read_state,
    output dircc_types_pkg::device_state_t          write_state,
    output logic                                    write_state_valid,
    output logic                                    packet_handled
);

    import dircc_types_pkg::*;

    device_state_t next_state;
    port_t         mark_port;

    // payload bits above the accum field name the port to mark
    assign mark_port = port_t'(packet_in.data[`DIRCC_MEM_WIDTH +: $bits(port_t)]);

    always_comb begin
        next_state         = read_state;
        next_state.accum   = read_state.accum + accum_t'(packet_in.data);   // wraps
        next_state.pending[mark_port] = 1'b1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            write_state_valid <= 1'b0;
        else
            write_state_valid <= receive_done;
    end

    always_ff @(posedge clk) begin
        if (receive_done)
            write_state <= next_state;
    end

    assign packet_handled = write_state_valid;  // single cycle handler

endmodule

`default_nettype wire

// File: verilog/dircc_send_handler.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_send_handler (
    input  wire dircc_types_pkg::device_state_t     read_state,
    input  wire dircc_types_pkg::port_t             port_index,
    output dircc_types_pkg::beat_t                  payload,
    output dircc_types_pkg::device_state_t          next_state
);

    import dircc_types_pkg::*;

    // every port carries the same value, the running sum
    assign payload = beat_t'(read_state.accum);

    always_comb begin
        next_state = read_state;
        next_state.pending[port_index] = 1'b0;  // this port has sent
    end

endmodule

`default_nettype wire

// File: verilog/dircc_status_register.sv
`timescale 1ns/100ps
`default_nettype none
`include "dircc_config.svh"

module dircc_status_register (
    input  wire                                     clk,
    input  wire                                     reset_n,
    input  wire [`DIRCC_MEM_ADDR_WIDTH-1:0]         mem_address,
    input  wire                                     mem_write,
    input  wire [`DIRCC_MEM_WIDTH-1:0]              mem_writedata,
    input  wire dircc_types_pkg::device_state_t     write_state,
    input  wire                                     write_state_valid,
    input  wire [`DIRCC_MEM_WIDTH-1:0]              lamport_low,
    output logic [`DIRCC_MEM_WIDTH-1:0]             mem_readdata,
    output dircc_types_pkg::device_state_t          read_state
);

    import dircc_types_pkg::*;

    localparam logic [`DIRCC_MEM_ADDR_WIDTH-1:0] reg_accum   = 0;
    localparam logic [`DIRCC_MEM_ADDR_WIDTH-1:0] reg_pending = 1;
    localparam logic [`DIRCC_MEM_ADDR_WIDTH-1:0] reg_lamport = 2;

    device_state_t state;
    device_state_t state_next;

    // handlers see a write in flight, so back to back updates chain
    assign read_state = write_state_valid ? write_state : state;

    always_comb begin
        state_next = state;
        if (write_state_valid)
            state_next = write_state;
        if (mem_write) begin    // host wins
            case (mem_address)
                reg_accum:   state_next.accum   = accum_t'(mem_writedata);
                reg_pending: state_next.pending = mem_writedata[`DIRCC_NUM_PORTS-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= '0;
        else
            state <= state_next;
    end

    always_ff @(posedge clk) begin
        case (mem_address)
            reg_accum:   mem_readdata <= state.accum;
            reg_pending: mem_readdata <= `DIRCC_MEM_WIDTH'(state.pending);
            reg_lamport: mem_readdata <= lamport_low;
            default:     mem_readdata <= '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/dircc_types_pkg.sv
`default_nettype none
`include "dircc_config.svh"

package dircc_types_pkg;

    typedef logic [`DIRCC_HW_ADDR_WIDTH-1:0] hw_addr_t;
    typedef logic [$clog2(`DIRCC_NUM_PORTS)-1:0] port_t;
    typedef logic [`DIRCC_NUM_PORTS-1:0] port_mask_t;
    typedef logic [`DIRCC_MEM_WIDTH-1:0] accum_t;
    typedef logic [`DIRCC_DATA_WIDTH-1:0] lamport_t;
    typedef logic [`DIRCC_DATA_WIDTH-1:0] beat_t;

    // 16 bit node/device/port address, half a beat
    typedef struct packed {
        hw_addr_t    hw_addr;
        logic [1:0]  sw_addr;
        port_t       port;
    } dircc_address_t;

    typedef struct packed {
        accum_t      accum;
        port_mask_t  pending;   // ready to send, one bit per port
    } device_state_t;

    // msb first on the wire: beat 0 is dest/src, beat 1 lamport, beat 2 data
    typedef struct packed {
        dircc_address_t  dest_addr;
        dircc_address_t  src_addr;
        lamport_t        lamport;
        beat_t           data;
    } packet_t;

endpackage

`default_nettype wire
